/* Makefile */
# Verilator build and run of the osf_top testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build osf_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# A $fatal in the testbench gives a nonzero exit status
test:
	verilator --binary --timing -sv -Wno-fatal \
		--top-module osf_tb \
		-Mdir obj_dir \
		-f osf_top.f
	./obj_dir/Vosf_tb

clean:
	rm -rf obj_dir

/* dv/osf_tb.sv */
`timescale 1ns/10ps

module osf_tb
    import osf_map_pkg::*;
    import osf_data_pkg::*;
();

    // --------------------------------------------------
    // Constants and types
    // --------------------------------------------------
    localparam int W_CHAN     = (DEF_N_CHAN > 1) ? $clog2(DEF_N_CHAN) : 1;
    localparam int IDLE_LIMIT = 64;

    // Accumulator limits
    localparam longint SUM_MAX = (longint'(1) << (DEF_W_SUM - 1)) - 1;
    localparam longint SUM_MIN = -(longint'(1) << (DEF_W_SUM - 1));

    // Sample limits
    localparam logic signed [DEF_W_DATA-1:0] DATA_MAX = {1'b0, {(DEF_W_DATA-1){1'b1}}};
    localparam logic signed [DEF_W_DATA-1:0] DATA_MIN = {1'b1, {(DEF_W_DATA-1){1'b0}}};

    // Not in the register map
    localparam logic [W_WR_ADDR-1:0] BAD_ADDR = 16'h0012;

    // Burst data modes
    localparam int MODE_RAND = 0;
    localparam int MODE_POS  = 1;
    localparam int MODE_NEG  = 2;

    // Sample of the reset row that the reset lands on
    localparam int RST_AT = 8;

    typedef enum {PH_OS, PH_CLR, PH_BAD, PH_BURST, PH_RST} phase_e;

    typedef struct {
        phase_e kind;
        int     chan;
        int     value;
        int     count;
    } row_t;

    typedef struct {
        logic [W_CHAN-1:0]            chan;
        logic signed [DEF_W_DATA-1:0] data;
        int                           due;
    } exp_t;

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    localparam int N_ROWS = 17;

    // kind, channel, exponent or data or mode, samples
    row_t rows [N_ROWS] = '{
        '{PH_BURST, 0,  MODE_RAND, 16},
        '{PH_OS,    1,  1,         0},
        '{PH_OS,    2,  2,         0},
        '{PH_OS,    3,  3,         0},
        '{PH_OS,    4,  5,         0},
        '{PH_BURST, 0,  MODE_RAND, 256},
        '{PH_BURST, 0,  MODE_POS,  256},
        '{PH_BURST, 0,  MODE_NEG,  256},
        // Partial sums on ch3 and ch4, then clear ch3
        '{PH_BURST, 0,  MODE_RAND, 21},
        '{PH_CLR,   3,  1,         0},
        '{PH_BURST, 0,  MODE_RAND, 64},
        // Out-of-range channels alias ch0 and ch4 in the low bits
        '{PH_BAD,   8,  7,         0},
        '{PH_BAD,   12, 1,         0},
        '{PH_BAD,   4,  1,         0},
        '{PH_BURST, 0,  MODE_RAND, 176},
        // Reset in the middle of this burst
        '{PH_RST,   0,  MODE_RAND, 24},
        '{PH_BURST, 0,  MODE_RAND, 16}
    };

    // --------------------------------------------------
    // DUT and clock
    // --------------------------------------------------
    logic                         clk_in;
    logic                         rst;
    logic                         dv_in;
    logic [W_CHAN-1:0]            chan_in;
    logic signed [DEF_W_DATA-1:0] data_in;
    logic                         wr_en;
    logic [W_WR_ADDR-1:0]         wr_addr;
    logic [W_WR_CHAN-1:0]         wr_chan;
    logic [W_WR_DATA-1:0]         wr_data;
    logic                         dv_out;
    logic [W_CHAN-1:0]            chan_out;
    logic signed [DEF_W_DATA-1:0] data_out;

    osf_top u_osf_top (
        .clk_in   (clk_in),
        .rst      (rst),
        .dv_in    (dv_in),
        .chan_in  (chan_in),
        .data_in  (data_in),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .dv_out   (dv_out),
        .chan_out (chan_out),
        .data_out (data_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // Rising edges seen so far
    int edge_cnt = 0;

    always @(posedge clk_in) begin
        edge_cnt <= edge_cnt + 1;
    end

    // --------------------------------------------------
    // Reference model state
    // --------------------------------------------------
    longint      sum_ref [DEF_N_CHAN];
    int          cnt_ref [DEF_N_CHAN];
    int          os_ref  [DEF_N_CHAN];
    exp_t        exp_q [$];
    logic [15:0] lfsr;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Run stopped at first error");
    endtask

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic make_sample(input int mode, output logic signed [DEF_W_DATA-1:0] d);
        logic [31:0] bits;
        case (mode)
            MODE_POS: begin
                take_bits(4, bits);
                d = DATA_MAX - bits[3:0];
            end
            MODE_NEG: begin
                take_bits(4, bits);
                d = DATA_MIN + bits[3:0];
            end
            default: begin
                take_bits(DEF_W_DATA, bits);
                d = bits[DEF_W_DATA-1:0];
            end
        endcase
    endtask

    task automatic model_reset();
        for (int i = 0; i < DEF_N_CHAN; i++) begin
            sum_ref[i] = 0;
            cnt_ref[i] = 0;
            os_ref[i]  = 0;
        end
    endtask

    // Saturating sum with the average emitted after 2^os samples
    task automatic model_sample(input int ch, input logic signed [DEF_W_DATA-1:0] d,
                                input int due);
        longint acc;
        longint avg;
        exp_t   e;
        acc = sum_ref[ch] + longint'(d);
        if (acc > SUM_MAX) begin
            acc = SUM_MAX;
        end else if (acc < SUM_MIN) begin
            acc = SUM_MIN;
        end
        sum_ref[ch] = acc;
        cnt_ref[ch] = cnt_ref[ch] + 1;
        if (cnt_ref[ch] == (1 << os_ref[ch])) begin
            avg    = acc >>> os_ref[ch];
            e.chan = W_CHAN'(ch);
            // Truncated to sample width
            e.data = avg[DEF_W_DATA-1:0];
            e.due  = due;
            exp_q.push_back(e);
            sum_ref[ch] = 0;
            cnt_ref[ch] = 0;
        end
    endtask

    // Results not yet out when reset lands are lost
    task automatic drop_in_flight(input int thr);
        while (exp_q.size() > 0 && exp_q[exp_q.size()-1].due >= thr) begin
            void'(exp_q.pop_back());
        end
    endtask

    // --------------------------------------------------
    // Compare tasks and output monitor
    // --------------------------------------------------
    task automatic check_chan(input logic [W_CHAN-1:0] got, input logic [W_CHAN-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch at %0t: chan_out = %0d, expected %0d",
                                   $time, got, exp));
        end
    endtask

    task automatic check_data(input logic signed [DEF_W_DATA-1:0] got,
                              input logic signed [DEF_W_DATA-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch at %0t: data_out = %0d, expected %0d",
                                   $time, got, exp));
        end
    endtask

    // Each pulse checked against the head of the queue
    always @(negedge clk_in) begin
        // Nothing is registered before the first rising edge
        if (edge_cnt > 0) begin
            if (dv_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    report_error($sformatf("Unexpected dv_out pulse at %0t", $time));
                end else if (exp_q[0].due != edge_cnt) begin
                    report_error($sformatf("dv_out pulse at edge %0d, expected at edge %0d",
                                           edge_cnt, exp_q[0].due));
                end else begin
                    check_chan(chan_out, exp_q[0].chan);
                    check_data(data_out, exp_q[0].data);
                    void'(exp_q.pop_front());
                end
            end else if (dv_out !== 1'b0) begin
                report_error($sformatf("dv_out is unknown at %0t", $time));
            end else if (exp_q.size() != 0 && exp_q[0].due < edge_cnt) begin
                report_error($sformatf("Expected dv_out pulse missing at edge %0d",
                                       exp_q[0].due));
            end
        end
    end

    // --------------------------------------------------
    // Drivers
    // --------------------------------------------------

    // Pipeline drained and all expected pulses seen
    task automatic wait_idle();
        int n;
        repeat (4) @(posedge clk_in);
        n = 0;
        while (exp_q.size() != 0 && n < IDLE_LIMIT) begin
            @(posedge clk_in);
            n++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("Timeout with %0d dv_out pulses still expected",
                                   exp_q.size()));
        end
    endtask

    task automatic write_reg(input logic [W_WR_ADDR-1:0] addr, input int ch, input int d);
        @(posedge clk_in);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_chan <= W_WR_CHAN'(ch);
        wr_data <= W_WR_DATA'(d);
        @(posedge clk_in);
        wr_en <= 1'b0;
        // Clear request lives one cycle after the write
        repeat (2) @(posedge clk_in);
    endtask

    // Round-robin channels so each recurs every 8 cycles
    // Reset lands with sample rst_at when rst_at is not negative
    task automatic send_burst(input int start, input int mode, input int n, input int rst_at);
        logic signed [DEF_W_DATA-1:0] d;
        int                           ch;
        for (int i = 0; i < n; i++) begin
            ch = (start + i) % DEF_N_CHAN;
            make_sample(mode, d);
            @(posedge clk_in);
            dv_in   <= 1'b1;
            chan_in <= W_CHAN'(ch);
            data_in <= d;
            if (i == rst_at) begin
                // Two edges of reset drop this sample and the next
                rst <= 1'b1;
                drop_in_flight(edge_cnt + 2);
                model_reset();
            end else if (rst_at >= 0 && i == rst_at + 2) begin
                rst <= 1'b0;
            end
            if (rst_at < 0 || i < rst_at || i > rst_at + 1) begin
                // Result due three cycles after dv_in
                model_sample(ch, d, edge_cnt + 4);
            end
        end
        @(posedge clk_in);
        dv_in <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        wait_idle();
        case (r.kind)
            PH_OS: begin
                write_reg(OVR_OS_ADDR, r.chan, r.value);
                os_ref[r.chan] = r.value % (1 << DEF_W_OS);
            end
            PH_CLR: begin
                write_reg(OVR_CLR_RQST, r.chan, r.value);
                sum_ref[r.chan] = 0;
                cnt_ref[r.chan] = 0;
            end
            PH_BAD: begin
                // Model left untouched since nothing may change
                if (r.chan < DEF_N_CHAN) begin
                    write_reg(BAD_ADDR, r.chan, r.value);
                end else begin
                    write_reg(OVR_OS_ADDR, r.chan, r.value);
                    write_reg(OVR_CLR_RQST, r.chan, r.value);
                end
            end
            PH_RST: begin
                send_burst(r.chan, r.value, r.count, RST_AT);
            end
            default: begin
                send_burst(r.chan, r.value, r.count, -1);
            end
        endcase
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst     = 1'b1;
        dv_in   = 1'b0;
        chan_in = '0;
        data_in = '0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_chan = '0;
        wr_data = '0;
        lfsr    = 16'd22585;
        model_reset();
        // Reset held over the first two rising edges
        repeat (2) @(posedge clk_in);
        rst <= 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(rows[i]);
        end
        wait_idle();
        // Quiet tail where a stray pulse still fails
        repeat (16) @(posedge clk_in);
        $display("Regression passed");
        $finish;
    end

endmodule

/* osf_top.f */
rtl/osf_map_pkg.sv
rtl/osf_data_pkg.sv
rtl/osf_regs.sv
rtl/osf_filter.sv
rtl/osf_top.sv
dv/osf_tb.sv

/* rtl/osf_data_pkg.sv */
package osf_data_pkg;

    // --------------------------------------------------
    // Data path defaults
    // --------------------------------------------------

    // Number of time-multiplexed channels
    localparam int DEF_N_CHAN = 8;

    // Signed sample width on input and output
    localparam int DEF_W_DATA = 18;

    // Accumulator width, small enough to saturate at os 5
    localparam int DEF_W_SUM  = 22;

    // Exponent width, os 0 to 7, 8-bit sample count
    localparam int DEF_W_OS   = 3;

endpackage

/* rtl/osf_filter.sv */
`timescale 1ns/10ps

module osf_filter
    import osf_data_pkg::*;
#(
    parameter int N_CHAN = DEF_N_CHAN,
    parameter int W_DATA = DEF_W_DATA,
    parameter int W_SUM  = DEF_W_SUM,
    parameter int W_OS   = DEF_W_OS,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic                      clk_in,
    input  logic                      rst,

    // Sample stream in
    input  logic                      dv_in,
    input  logic [W_CHAN-1:0]         chan_in,
    input  logic signed [W_DATA-1:0]  data_in,

    // From register block
    input  logic [N_CHAN*W_OS-1:0]    os_modes,
    input  logic [N_CHAN-1:0]         clr_rqst,

    // Averaged stream out
    output logic                      dv_out,
    output logic [W_CHAN-1:0]         chan_out,
    output logic signed [W_DATA-1:0]  data_out
);

    // --------------------------------------------------
    // Constants
    // --------------------------------------------------

    // Count must reach 2^os, os up to 2^W_OS-1
    localparam int W_COUNT   = 2**W_OS;
    // One guard bit above the wider operand
    localparam int W_SUM_INT = ((W_SUM > W_DATA) ? W_SUM : W_DATA) + 1;

    // Signed limits of the accumulator
    localparam logic signed [W_SUM-1:0] MAX_SUM = {1'b0, {(W_SUM-1){1'b1}}};
    localparam logic signed [W_SUM-1:0] MIN_SUM = {1'b1, {(W_SUM-1){1'b0}}};

    // --------------------------------------------------
    // Per-channel accumulation state
    // --------------------------------------------------
    logic signed [W_SUM-1:0] sum_mem   [N_CHAN];
    logic [W_COUNT-1:0]      count_mem [N_CHAN];

    // --------------------------------------------------
    // Stage 1: fetch
    // --------------------------------------------------
    logic                     flush_p1;
    logic                     dv_p1;
    logic [W_CHAN-1:0]        chan_p1;
    logic signed [W_DATA-1:0] din_p1;
    logic signed [W_SUM-1:0]  sum_p1;
    logic [W_COUNT-1:0]       count_p1;

    // Incoming sample of a channel being cleared
    assign flush_p1 = rst || clr_rqst[chan_in];

    always_ff @(posedge clk_in) begin
        if (flush_p1) begin
            dv_p1 <= 1'b0;
        end else begin
            dv_p1 <= dv_in;
        end
    end

    // Payload and memory read
    always_ff @(posedge clk_in) begin
        chan_p1  <= chan_in;
        din_p1   <= data_in;
        sum_p1   <= sum_mem[chan_in];
        count_p1 <= count_mem[chan_in];
    end

    // --------------------------------------------------
    // Stage 2: accumulate
    // --------------------------------------------------
    logic                        flush_p2;
    logic signed [W_SUM_INT-1:0] sum_int_p2;
    logic signed [W_SUM-1:0]     sum_sat_p2;
    logic                        dv_p2;
    logic [W_CHAN-1:0]           chan_p2;
    logic signed [W_SUM-1:0]     sum_p2;
    logic [W_COUNT-1:0]          count_p2;
    logic [W_OS-1:0]             os_p2;

    assign flush_p2 = rst || clr_rqst[chan_p1];

    always_comb begin
        // Both operands sign-extended to the guard width
        sum_int_p2 = sum_p1 + din_p1;

        // Clamp to accumulator range
        if (sum_int_p2 > MAX_SUM) begin
            sum_sat_p2 = MAX_SUM;
        end else if (sum_int_p2 < MIN_SUM) begin
            sum_sat_p2 = MIN_SUM;
        end else begin
            sum_sat_p2 = sum_int_p2[W_SUM-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (flush_p2) begin
            dv_p2 <= 1'b0;
        end else begin
            dv_p2 <= dv_p1;
        end
    end

    always_ff @(posedge clk_in) begin
        chan_p2  <= chan_p1;
        sum_p2   <= sum_sat_p2;
        count_p2 <= count_p1 + 1'b1;
        // Exponent of this sample's channel
        os_p2    <= os_modes[chan_p1*W_OS +: W_OS];
    end

    // --------------------------------------------------
    // Stage 3: divide and writeback
    // --------------------------------------------------
    logic                        flush_p3;
    logic                        count_sat_p3;
    logic signed [W_SUM_INT-1:0] sum_ext_p3;
    logic signed [W_SUM_INT-1:0] sum_div_p3;
    logic signed [W_SUM-1:0]     sum_wb_p3;
    logic [W_COUNT-1:0]          count_wb_p3;
    logic                        dv_p3;
    logic [W_CHAN-1:0]           chan_p3;
    logic signed [W_DATA-1:0]    dout_p3;

    assign flush_p3 = rst || clr_rqst[chan_p2];

    always_comb begin
        // Count bit os set once 2^os samples are in
        count_sat_p3 = count_p2[os_p2];

        // Arithmetic shift keeps the sign
        sum_ext_p3 = sum_p2;
        sum_div_p3 = sum_ext_p3 >>> os_p2;

        // Restart the channel when it fires
        sum_wb_p3   = count_sat_p3 ? '0 : sum_p2;
        count_wb_p3 = count_sat_p3 ? '0 : count_p2;
    end

    // Writeback, zeroed per channel on reset or clear
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < N_CHAN; i++) begin
            if (rst || clr_rqst[i]) begin
                sum_mem[i]   <= '0;
                count_mem[i] <= '0;
            end else if (dv_p2 && (chan_p2 == W_CHAN'(i))) begin
                sum_mem[i]   <= sum_wb_p3;
                count_mem[i] <= count_wb_p3;
            end
        end
    end

    // Output strobe only on a completed count
    always_ff @(posedge clk_in) begin
        if (flush_p3) begin
            dv_p3 <= 1'b0;
        end else begin
            dv_p3 <= dv_p2 && count_sat_p3;
        end
    end

    always_ff @(posedge clk_in) begin
        chan_p3 <= chan_p2;
        // Truncate the average to sample width
        dout_p3 <= sum_div_p3[W_DATA-1:0];
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign dv_out   = dv_p3;
    assign chan_out = chan_p3;
    assign data_out = dout_p3;

endmodule

/* rtl/osf_map_pkg.sv */
package osf_map_pkg;

    // --------------------------------------------------
    // Register address map
    // --------------------------------------------------

    // Per-channel registers, channel carried on wr_chan
    typedef enum logic [15:0] {
        // Oversample exponent, low bits of wr_data
        OVR_OS_ADDR  = 16'h0010,
        // One-shot clear, wr_data bit 0
        OVR_CLR_RQST = 16'h0011
    } reg_addr_e;

    // --------------------------------------------------
    // Write strobe bus field widths
    // --------------------------------------------------
    localparam int W_WR_ADDR = 16;
    localparam int W_WR_CHAN = 16;
    localparam int W_WR_DATA = 48;

endpackage

/* rtl/osf_regs.sv */
`timescale 1ns/10ps

module osf_regs
    import osf_map_pkg::*;
    import osf_data_pkg::*;
#(
    parameter int N_CHAN = DEF_N_CHAN,
    parameter int W_OS   = DEF_W_OS
) (
    input  logic                     clk_in,
    input  logic                     rst,

    // Write strobe bus
    input  logic                     wr_en,
    input  logic [W_WR_ADDR-1:0]     wr_addr,
    input  logic [W_WR_CHAN-1:0]     wr_chan,
    input  logic [W_WR_DATA-1:0]     wr_data,

    // To filter
    output logic [N_CHAN*W_OS-1:0]   os_modes,
    output logic [N_CHAN-1:0]        clr_rqst
);

    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------
    logic              chan_ok;
    logic [W_CHAN-1:0] chan_idx;
    logic              os_we;
    logic              clr_we;

    always_comb begin
        // Out-of-range channels are dropped here
        chan_ok  = (wr_chan < W_WR_CHAN'(N_CHAN));
        chan_idx = wr_chan[W_CHAN-1:0];
        os_we    = 1'b0;
        clr_we   = 1'b0;
        if (wr_en && chan_ok) begin
            case (reg_addr_e'(wr_addr))
                OVR_OS_ADDR:  os_we  = 1'b1;
                OVR_CLR_RQST: clr_we = 1'b1;
                // Unknown address, no effect
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // Exponent storage
    // --------------------------------------------------
    logic [W_OS-1:0] os_q [N_CHAN];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < N_CHAN; i++) begin
                os_q[i] <= '0;
            end
        end else if (os_we) begin
            // Only the low W_OS data bits are kept
            os_q[chan_idx] <= wr_data[W_OS-1:0];
        end
    end

    // Flatten for the filter
    for (genvar g = 0; g < N_CHAN; g++) begin : g_os_flat
        assign os_modes[g*W_OS +: W_OS] = os_q[g];
    end

    // --------------------------------------------------
    // Clear request
    // --------------------------------------------------
    logic [N_CHAN-1:0] clr_q;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            clr_q <= '0;
        end else begin
            // Self-clearing, high for one cycle per write
            clr_q <= '0;
            if (clr_we) begin
                clr_q[chan_idx] <= wr_data[0];
            end
        end
    end

    assign clr_rqst = clr_q;

endmodule

/* rtl/osf_top.sv */
`timescale 1ns/10ps

module osf_top
    import osf_map_pkg::*;
    import osf_data_pkg::*;
#(
    parameter int N_CHAN = DEF_N_CHAN,
    parameter int W_DATA = DEF_W_DATA,
    parameter int W_SUM  = DEF_W_SUM,
    parameter int W_OS   = DEF_W_OS,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic                      clk_in,
    input  logic                      rst,

    // Sample stream
    input  logic                      dv_in,
    input  logic [W_CHAN-1:0]         chan_in,
    input  logic signed [W_DATA-1:0]  data_in,

    // Register writes
    input  logic                      wr_en,
    input  logic [W_WR_ADDR-1:0]      wr_addr,
    input  logic [W_WR_CHAN-1:0]      wr_chan,
    input  logic [W_WR_DATA-1:0]      wr_data,

    // Averaged results
    output logic                      dv_out,
    output logic [W_CHAN-1:0]         chan_out,
    output logic signed [W_DATA-1:0]  data_out
);

    // Register block to filter
    logic [N_CHAN*W_OS-1:0] os_modes;
    logic [N_CHAN-1:0]      clr_rqst;

    // --------------------------------------------------
    // Register block
    // --------------------------------------------------
    osf_regs #(
        .N_CHAN   (N_CHAN),
        .W_OS     (W_OS)
    ) u_osf_regs (
        .clk_in   (clk_in),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .os_modes (os_modes),
        .clr_rqst (clr_rqst)
    );

    // --------------------------------------------------
    // Filter pipeline
    // --------------------------------------------------
    osf_filter #(
        .N_CHAN   (N_CHAN),
        .W_DATA   (W_DATA),
        .W_SUM    (W_SUM),
        .W_OS     (W_OS)
    ) u_osf_filter (
        .clk_in   (clk_in),
        .rst      (rst),
        .dv_in    (dv_in),
        .chan_in  (chan_in),
        .data_in  (data_in),
        .os_modes (os_modes),
        .clr_rqst (clr_rqst),
        .dv_out   (dv_out),
        .chan_out (chan_out),
        .data_out (data_out)
    );

endmodule
